// ==== rtl/bp_macros.svh ====
// Geometry macros for the branch prediction front end: address width and table sizes
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Address width
//////////////////////////////////////////////////////////////////////
`define XLEN 32

//////////////////////////////////////////////////////////////////////
// Branch target buffer, direct mapped
//////////////////////////////////////////////////////////////////////
`define BTB_IDX_LEN 4
`define BTB_SIZE 16

//////////////////////////////////////////////////////////////////////
// History table of 2-bit counters
//////////////////////////////////////////////////////////////////////
`define BHT_IDX_LEN 6
`define BHT_SIZE 64

`endif

// ==== rtl/bp_pkg.sv ====
// Shared address, tag, index and counter types for the branch predictor
`include "bp_macros.svh"

package bp_pkg;

   // Full instruction address
   typedef logic [`XLEN-1:0] pc_t;

   // BTB fields cut from PC bits 15 down to 2
   typedef logic [13-`BTB_IDX_LEN:0] btb_tag_t;
   typedef logic [`BTB_IDX_LEN-1:0] btb_idx_t;

   // Stored target word, PC bits 15 to 2
   typedef logic [13:0] btb_tgt_t;

   // History table index, PC bits BHT_IDX_LEN+1 down to 2
   typedef logic [`BHT_IDX_LEN-1:0] bht_idx_t;

   // 0 strongly not-taken, 1 weakly not-taken,
   // 2 weakly taken, 3 strongly taken
   typedef logic [1:0] bht_cnt_t;

endpackage

// ==== rtl/btb_2.sv ====
// Direct-mapped branch target buffer with two lookup ports and two write ports
`timescale 1ns/10ps
`include "bp_macros.svh"

module btb_2 (
   input  logic          clock,
   input  logic          reset,

   // Lookup side
   input  logic          read_en_0,
   input  logic          read_en_1,
   input  bp_pkg::pc_t   pc_r_0,
   input  bp_pkg::pc_t   pc_r_1,

   // Retirement updates
   input  logic          update_en_0,
   input  logic          update_en_1,
   input  logic          update_taken_0,
   input  logic          update_taken_1,
   input  bp_pkg::pc_t   update_pc_0,
   input  bp_pkg::pc_t   update_pc_1,
   input  bp_pkg::pc_t   update_target_0,
   input  bp_pkg::pc_t   update_target_1,

   output logic          hit_0,
   output logic          hit_1,
   output bp_pkg::pc_t   target_0,
   output bp_pkg::pc_t   target_1
);
   import bp_pkg::*;

   logic [`BTB_SIZE-1:0] btb_valid;
   btb_tag_t             btb_tag [`BTB_SIZE];
   btb_tgt_t             btb_target [`BTB_SIZE];

   btb_tag_t rd_tag_0, rd_tag_1, wr_tag_0, wr_tag_1;
   btb_idx_t rd_idx_0, rd_idx_1, wr_idx_0, wr_idx_1;
   logic     wr_0, wr_1;

   assign {rd_tag_0, rd_idx_0} = pc_r_0[15:2];
   assign {rd_tag_1, rd_idx_1} = pc_r_1[15:2];
   assign {wr_tag_0, wr_idx_0} = update_pc_0[15:2];
   assign {wr_tag_1, wr_idx_1} = update_pc_1[15:2];

   //////////////////////////////////////////////////////////////////////
   // Purely combinational lookup
   //////////////////////////////////////////////////////////////////////
   assign hit_0 = read_en_0 && btb_valid[rd_idx_0] && (btb_tag[rd_idx_0] == rd_tag_0);
   assign hit_1 = read_en_1 && btb_valid[rd_idx_1] && (btb_tag[rd_idx_1] == rd_tag_1);

   // Rebuild the target with zero upper and lower bits
   assign target_0 = hit_0 ? {{(`XLEN-16){1'b0}}, btb_target[rd_idx_0], 2'b00} : '0;
   assign target_1 = hit_1 ? {{(`XLEN-16){1'b0}}, btb_target[rd_idx_1], 2'b00} : '0;

   //////////////////////////////////////////////////////////////////////
   // Install taken branches
   //////////////////////////////////////////////////////////////////////
   assign wr_0 = update_en_0 && update_taken_0;
   // Slot 1 steps aside when slot 0 writes the same entry
   assign wr_1 = update_en_1 && update_taken_1 && !(wr_0 && (wr_idx_1 == wr_idx_0));

   always_ff @(posedge clock) begin
      if (reset) begin
         btb_valid  <= '0;
         btb_tag    <= '{default: '0};
         btb_target <= '{default: '0};
      end else begin
         if (wr_0) begin
            btb_valid[wr_idx_0]  <= 1'b1;
            btb_tag[wr_idx_0]    <= wr_tag_0;
            btb_target[wr_idx_0] <= update_target_0[15:2];
         end
         if (wr_1) begin
            btb_valid[wr_idx_1]  <= 1'b1;
            btb_tag[wr_idx_1]    <= wr_tag_1;
            btb_target[wr_idx_1] <= update_target_1[15:2];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////
   // Retirement must never present unknown strobes
   a_update_known: assert property (@(posedge clock) disable iff (reset)
      !$isunknown({update_en_0, update_en_1}));

endmodule

// ==== rtl/bht_2.sv ====
// Direct-mapped history table of 2-bit saturating counters, two lookups and two updates
`timescale 1ns/10ps
`include "bp_macros.svh"

module bht_2 (
   input  logic          clock,
   input  logic          reset,

   input  logic          read_en_0,
   input  logic          read_en_1,
   input  bp_pkg::pc_t   pc_r_0,
   input  bp_pkg::pc_t   pc_r_1,

   input  logic          update_en_0,
   input  logic          update_en_1,
   input  logic          update_taken_0,
   input  logic          update_taken_1,
   input  bp_pkg::pc_t   update_pc_0,
   input  bp_pkg::pc_t   update_pc_1,

   output logic          taken_0,
   output logic          taken_1
);
   import bp_pkg::*;

   bht_cnt_t bht_cnt [`BHT_SIZE];

   bht_idx_t rd_idx_0, rd_idx_1, upd_idx_0, upd_idx_1;
   logic     upd_1_apply;

   // One step of the saturating counter
   function automatic bht_cnt_t sat_step(input bht_cnt_t cnt, input logic taken);
      bht_cnt_t nxt;
      nxt = cnt;
      if (taken && cnt != 2'd3)
         nxt = cnt + 2'd1;
      else if (!taken && cnt != 2'd0)
         nxt = cnt - 2'd1;
      return nxt;
   endfunction

   assign rd_idx_0  = pc_r_0[`BHT_IDX_LEN+1:2];
   assign rd_idx_1  = pc_r_1[`BHT_IDX_LEN+1:2];
   assign upd_idx_0 = update_pc_0[`BHT_IDX_LEN+1:2];
   assign upd_idx_1 = update_pc_1[`BHT_IDX_LEN+1:2];

   // Upper counter bit means predict taken
   assign taken_0 = read_en_0 && bht_cnt[rd_idx_0][1];
   assign taken_1 = read_en_1 && bht_cnt[rd_idx_1][1];

   // Same-index conflict, slot 0 wins
   assign upd_1_apply = update_en_1 && !(update_en_0 && (upd_idx_1 == upd_idx_0));

   always_ff @(posedge clock) begin
      if (reset) begin
         // Start weakly not-taken
         bht_cnt <= '{default: 2'd1};
      end else begin
         if (update_en_0)
            bht_cnt[upd_idx_0] <= sat_step(bht_cnt[upd_idx_0], update_taken_0);
         if (upd_1_apply)
            bht_cnt[upd_idx_1] <= sat_step(bht_cnt[upd_idx_1], update_taken_1);
      end
   end

   // Saturated counters hold instead of wrapping
   a_no_wrap: assert property (@(posedge clock) disable iff (reset)
      (update_en_0 && update_taken_0 && bht_cnt[upd_idx_0] == 2'd3
         |=> bht_cnt[$past(upd_idx_0)] == 2'd3)
      and (update_en_0 && !update_taken_0 && bht_cnt[upd_idx_0] == 2'd0
         |=> bht_cnt[$past(upd_idx_0)] == 2'd0));

endmodule

// ==== rtl/next_pc_sel.sv ====
// Next fetch address selection from BTB hits and history predictions
`timescale 1ns/10ps
`include "bp_macros.svh"

module next_pc_sel (
   input  logic          fetch_en,
   input  bp_pkg::pc_t   fetch_pc,

   input  logic          hit_0,
   input  logic          hit_1,
   input  logic          taken_0,
   input  logic          taken_1,
   input  bp_pkg::pc_t   target_0,
   input  bp_pkg::pc_t   target_1,

   output bp_pkg::pc_t   next_pc,
   output logic          pred_taken_0,
   output logic          pred_taken_1
);
   import bp_pkg::*;

   pc_t  seq_pc;
   logic take_0, take_1;

   // Fall-through past both slots
   assign seq_pc = fetch_pc + `XLEN'(8);

   //////////////////////////////////////////////////////////////////////
   // Slot priority
   //////////////////////////////////////////////////////////////////////
   assign take_0 = fetch_en && hit_0 && taken_0;
   // Slot 1 only counts when slot 0 does not redirect
   assign take_1 = fetch_en && !take_0 && hit_1 && taken_1;

   assign pred_taken_0 = take_0;
   assign pred_taken_1 = take_1;

   always_comb begin
      if (!fetch_en)
         next_pc = fetch_pc;   // hold fetch
      else if (take_0)
         next_pc = target_0;
      else if (take_1)
         next_pc = target_1;
      else
         next_pc = seq_pc;
   end

endmodule

// ==== rtl/branch_pred_top.sv ====
// Branch prediction front end for a two-wide fetch: BTB, history table and next-PC select
`timescale 1ns/10ps
`include "bp_macros.svh"

module branch_pred_top (
   input  logic          clock,
   input  logic          reset,
   input  logic          fetch_en,
   input  bp_pkg::pc_t   fetch_pc,

   input  logic          update_en_0,
   input  logic          update_en_1,
   input  logic          update_taken_0,
   input  logic          update_taken_1,
   input  bp_pkg::pc_t   update_pc_0,
   input  bp_pkg::pc_t   update_pc_1,
   input  bp_pkg::pc_t   update_target_0,
   input  bp_pkg::pc_t   update_target_1,

   output bp_pkg::pc_t   next_pc,
   output logic          pred_taken_0,
   output logic          pred_taken_1
);
   import bp_pkg::*;

   // Second fetch slot sits one word above the first
   pc_t  fetch_pc_1;
   logic hit_0, hit_1;
   logic taken_0, taken_1;
   pc_t  target_0, target_1;

   assign fetch_pc_1 = fetch_pc + `XLEN'(4);

   //////////////////////////////////////////////////////////////////////
   // Tables
   //////////////////////////////////////////////////////////////////////
   btb_2 btb_i (
      .clock           (clock),
      .reset           (reset),
      .read_en_0       (fetch_en),
      .read_en_1       (fetch_en),
      .pc_r_0          (fetch_pc),
      .pc_r_1          (fetch_pc_1),
      .update_en_0     (update_en_0),
      .update_en_1     (update_en_1),
      .update_taken_0  (update_taken_0),
      .update_taken_1  (update_taken_1),
      .update_pc_0     (update_pc_0),
      .update_pc_1     (update_pc_1),
      .update_target_0 (update_target_0),
      .update_target_1 (update_target_1),
      .hit_0           (hit_0),
      .hit_1           (hit_1),
      .target_0        (target_0),
      .target_1        (target_1)
   );

   bht_2 bht_i (
      .clock          (clock),
      .reset          (reset),
      .read_en_0      (fetch_en),
      .read_en_1      (fetch_en),
      .pc_r_0         (fetch_pc),
      .pc_r_1         (fetch_pc_1),
      .update_en_0    (update_en_0),
      .update_en_1    (update_en_1),
      .update_taken_0 (update_taken_0),
      .update_taken_1 (update_taken_1),
      .update_pc_0    (update_pc_0),
      .update_pc_1    (update_pc_1),
      .taken_0        (taken_0),
      .taken_1        (taken_1)
   );

   //////////////////////////////////////////////////////////////////////
   // Redirect
   //////////////////////////////////////////////////////////////////////
   next_pc_sel sel_i (
      .fetch_en     (fetch_en),
      .fetch_pc     (fetch_pc),
      .hit_0        (hit_0),
      .hit_1        (hit_1),
      .taken_0      (taken_0),
      .taken_1      (taken_1),
      .target_0     (target_0),
      .target_1     (target_1),
      .next_pc      (next_pc),
      .pred_taken_0 (pred_taken_0),
      .pred_taken_1 (pred_taken_1)
   );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Clock and synchronous reset source for the branch predictor testbench
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clock,
   output logic reset
);
   localparam int HALF_PERIOD  = 50;
   localparam int RESET_CYCLES = 5;

   initial begin
      clock = 1'b0;
      forever #(HALF_PERIOD) clock = ~clock;
   end

   // Release reset just after the fifth rising edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clock);
      #1 reset = 1'b0;
   end

endmodule

// ==== testbench/tb_branch_pred.sv ====
// Branch predictor testbench that checks directed and random stimulus against a reference model
`timescale 1ns/10ps
`include "bp_macros.svh"

module tb_branch_pred;
   import bp_pkg::*;

   localparam int RAND_CYCLES     = 2000;
   // Upper bound on the directed tests
   localparam int DIRECTED_CYCLES = 100;
   localparam int TOTAL_CYCLES    = 5 + DIRECTED_CYCLES + RAND_CYCLES;
   localparam int POOL_SIZE       = 12;

   logic clock, reset, fetch_en;
   pc_t  fetch_pc, next_pc;
   logic update_en_0, update_en_1, update_taken_0, update_taken_1;
   pc_t  update_pc_0, update_pc_1, update_target_0, update_target_1;
   logic pred_taken_0, pred_taken_1;

   // Reference model, full branch PC kept per BTB entry
   logic m_valid [`BTB_SIZE];
   pc_t  m_branch [`BTB_SIZE];
   pc_t  m_target [`BTB_SIZE];
   int   m_count [`BHT_SIZE];

   pc_t  pool [POOL_SIZE];
   int   test_errors, tests_passed, tests_failed;

   tb_clock_gen clk_i (.clock(clock), .reset(reset));

   branch_pred_top dut_i (
      .clock(clock), .reset(reset), .fetch_en(fetch_en), .fetch_pc(fetch_pc),
      .update_en_0(update_en_0), .update_en_1(update_en_1),
      .update_taken_0(update_taken_0), .update_taken_1(update_taken_1),
      .update_pc_0(update_pc_0), .update_pc_1(update_pc_1),
      .update_target_0(update_target_0), .update_target_1(update_target_1),
      .next_pc(next_pc), .pred_taken_0(pred_taken_0), .pred_taken_1(pred_taken_1)
   );

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////
   function automatic int btb_index(input pc_t pc);
      return int'(pc[`BTB_IDX_LEN+1:2]);
   endfunction

   function automatic int bht_index(input pc_t pc);
      return int'(pc[`BHT_IDX_LEN+1:2]);
   endfunction

   function automatic logic model_hit(input pc_t pc);
      int i;
      i = btb_index(pc);
      return m_valid[i] && (m_branch[i][15:2] == pc[15:2]);
   endfunction

   function automatic int step_count(input int c, input logic taken);
      if (taken)
         return (c < 3) ? c + 1 : 3;
      return (c > 0) ? c - 1 : 0;
   endfunction

   task automatic install(input pc_t pc, input pc_t tgt);
      m_valid[btb_index(pc)]  = 1'b1;
      m_branch[btb_index(pc)] = pc;
      m_target[btb_index(pc)] = tgt & 32'h0000_fffc;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////
   task automatic compare_pc(input string name, input pc_t exp, input pc_t act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         test_errors++;
      end
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
         test_errors++;
      end
   endtask

   // Check before the edge, then apply the strobed updates to the model
   task automatic tick();
      pc_t  exp_next, pc1;
      logic exp_p0, exp_p1;
      int   c0, c1;
      #80;
      pc1    = fetch_pc + 4;
      exp_p0 = fetch_en && model_hit(fetch_pc) && (m_count[bht_index(fetch_pc)] >= 2);
      exp_p1 = fetch_en && !exp_p0 && model_hit(pc1) && (m_count[bht_index(pc1)] >= 2);
      if (!fetch_en)
         exp_next = fetch_pc;
      else if (exp_p0)
         exp_next = m_target[btb_index(fetch_pc)];
      else if (exp_p1)
         exp_next = m_target[btb_index(pc1)];
      else
         exp_next = fetch_pc + 8;
      compare_pc("next_pc", exp_next, next_pc);
      compare_flag("pred_taken_0", exp_p0, pred_taken_0);
      compare_flag("pred_taken_1", exp_p1, pred_taken_1);
      @(posedge clock);
      c0 = step_count(m_count[bht_index(update_pc_0)], update_taken_0);
      c1 = step_count(m_count[bht_index(update_pc_1)], update_taken_1);
      // Slot 1 goes first so slot 0 overwrites a shared entry
      if (update_en_1 && update_taken_1)
         install(update_pc_1, update_target_1);
      if (update_en_0 && update_taken_0)
         install(update_pc_0, update_target_0);
      if (update_en_1)
         m_count[bht_index(update_pc_1)] = c1;
      if (update_en_0)
         m_count[bht_index(update_pc_0)] = c0;
      #1;
      update_en_0 = 1'b0;
      update_en_1 = 1'b0;
   endtask

   task automatic fetch(input logic en, input pc_t pc);
      fetch_en = en;
      fetch_pc = pc;
      tick();
   endtask

   task automatic set_update(input int slot, input pc_t pc, input logic taken, input pc_t tgt);
      if (slot == 0) begin
         update_en_0     = 1'b1;
         update_pc_0     = pc;
         update_taken_0  = taken;
         update_target_0 = tgt;
      end else begin
         update_en_1     = 1'b1;
         update_pc_1     = pc;
         update_taken_1  = taken;
         update_target_1 = tgt;
      end
   endtask

   task automatic finish_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d mismatches", name, test_errors);
      end
      test_errors = 0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Watchdog
   //////////////////////////////////////////////////////////////////////
   initial begin
      #(2 * TOTAL_CYCLES * 100);
      $display("Watchdog: the run did not finish within its time limit");
      $display("Test failed");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      void'($urandom(32'hb697));
      fetch_en = 1'b0;
      fetch_pc = '0;
      {update_en_0, update_en_1, update_taken_0, update_taken_1} = '0;
      {update_pc_0, update_pc_1, update_target_0, update_target_1} = '0;
      test_errors  = 0;
      tests_passed = 0;
      tests_failed = 0;
      for (int i = 0; i < `BTB_SIZE; i++) begin
         m_valid[i]  = 1'b0;
         m_branch[i] = '0;
         m_target[i] = '0;
      end
      for (int i = 0; i < `BHT_SIZE; i++)
         m_count[i] = 1;
      // Few tags and indices so entries alias
      for (int i = 0; i < POOL_SIZE; i++)
         pool[i] = 32'h1000 | (($urandom % 4) << 6) | (($urandom % 16) << 2);
      while (reset !== 1'b0)
         @(posedge clock);
      #1;

      for (int i = 0; i < 8; i++) begin
         fetch(1'b1, pool[i]);
         fetch(1'b0, pool[i]);
      end
      finish_test("reset state");

      // Upper target bits are dropped by the BTB
      repeat (2) begin
         set_update(0, 32'h0000_1234, 1'b1, 32'h0005_2a40);
         fetch(1'b1, 32'h0000_1234);
      end
      fetch(1'b1, 32'h0000_1234);
      fetch(1'b1, 32'h0000_1230);
      finish_test("taken branch in slot 0 and slot 1");

      repeat (4) begin
         set_update(0, 32'h0000_1234, 1'b0, '0);
         fetch(1'b1, 32'h0000_1234);
      end
      fetch(1'b1, 32'h0000_1234);
      repeat (4) begin
         set_update(0, 32'h0000_1234, 1'b1, 32'h0005_2a40);
         fetch(1'b1, 32'h0000_1234);
      end
      set_update(0, 32'h0000_1234, 1'b0, '0);
      fetch(1'b1, 32'h0000_1234);
      fetch(1'b1, 32'h0000_1234);
      finish_test("counter saturation");

      set_update(0, 32'h0000_0040, 1'b1, 32'h0000_0100);
      set_update(1, 32'h0000_0840, 1'b1, 32'h0000_0200);
      fetch(1'b1, 32'h0000_0040);
      fetch(1'b1, 32'h0000_0040);
      fetch(1'b1, 32'h0000_0840);
      set_update(0, 32'h0000_0040, 1'b0, '0);
      set_update(1, 32'h0000_0840, 1'b1, 32'h0000_0200);
      fetch(1'b1, 32'h0000_0040);
      fetch(1'b1, 32'h0000_0040);
      fetch(1'b1, 32'h0000_0840);
      finish_test("same-cycle index conflict");

      repeat (2) begin
         set_update(0, 32'h0000_1100, 1'b1, 32'h0000_0400);
         fetch(1'b1, 32'h0000_1100);
      end
      set_update(0, 32'h0000_3100, 1'b1, 32'h0000_0800);
      fetch(1'b1, 32'h0000_1100);
      fetch(1'b1, 32'h0000_1100);
      fetch(1'b1, 32'h0000_3100);
      repeat (2) begin
         set_update(0, 32'h0000_2010, 1'b1, 32'h0000_0500);
         set_update(1, 32'h0000_2014, 1'b1, 32'h0000_0600);
         fetch(1'b1, 32'h0000_0000);
      end
      fetch(1'b1, 32'h0000_2010);
      finish_test("aliasing and slot priority");

      repeat (RAND_CYCLES) begin
         if ($urandom % 2)
            set_update(0, pool[$urandom % POOL_SIZE], ($urandom % 4) != 0, $urandom & 32'hfffc);
         if ($urandom % 2)
            set_update(1, pool[$urandom % POOL_SIZE], ($urandom % 4) != 0, $urandom & 32'hfffc);
         fetch(($urandom % 8) != 0, pool[$urandom % POOL_SIZE] - ((($urandom % 3) == 0) ? 4 : 0));
      end
      finish_test("random mix");

      $display("Summary: %0d tests ok, %0d tests with mismatches", tests_passed, tests_failed);
      if (tests_failed == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/bp_pkg.sv
rtl/btb_2.sv
rtl/bht_2.sv
rtl/next_pc_sel.sv
rtl/branch_pred_top.sv
testbench/tb_clock_gen.sv
testbench/tb_branch_pred.sv

// ==== Bender.yml ====
package:
  name: branch_pred

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bp_pkg.sv
      - rtl/btb_2.sv
      - rtl/bht_2.sv
      - rtl/next_pc_sel.sv
      - rtl/branch_pred_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_branch_pred.sv
